/* src/led_cal_pkg.sv */
`default_nettype none

package led_cal_pkg;

    // Strand geometry
    localparam int NUM_LEDS   = 50;
    localparam int LED_ID_W   = 7;                    // LED i shows ID i+1
    localparam int NUM_PLANES = 7;                    // One bit plane per captured frame
    localparam int BIT_SEL_W  = $clog2(NUM_PLANES);

    // Camera frame and table geometry
    localparam int FRAME_W       = 160;
    localparam int FRAME_H       = 120;
    localparam int NUM_PIXELS    = FRAME_W * FRAME_H; // 19200 table entries
    localparam int PIX_ADDR_W    = 15;
    localparam int PIX_W         = 16;                // Pixel and threshold width
    localparam int TABLE_LATENCY = 2;                 // Registered read, both ports

    // One pixel word, decoded two ways
    typedef union packed {
        logic [PIX_W-1:0] raw;                        // 16-bit grey
        struct packed {
            logic [4:0] r;
            logic [5:0] g;
            logic [4:0] b;
        } rgb565;
    } pixel_word_u;

endpackage

`default_nettype wire

/* src/cal_regs_pkg.sv */
`default_nettype none

package cal_regs_pkg;

    localparam int APB_ADDR_W = 8;
    localparam int APB_DATA_W = 32;

    // Register map
    localparam logic [APB_ADDR_W-1:0] REG_CTRL     = 8'h00;
    localparam logic [APB_ADDR_W-1:0] REG_BIT_SEL  = 8'h04;
    localparam logic [APB_ADDR_W-1:0] REG_THRESH   = 8'h08;
    localparam logic [APB_ADDR_W-1:0] REG_ON_COLOR = 8'h0C;
    localparam logic [APB_ADDR_W-1:0] REG_STATUS   = 8'h10;  // Read-only

    // CTRL fields
    localparam int CTRL_EN_BIT      = 0;
    localparam int CTRL_MODE_BIT    = 1;   // 1 selects RGB565
    localparam int CTRL_CAPTURE_BIT = 8;   // Writing 1 arms a capture and reads back 0

    // STATUS fields
    localparam int STAT_ARMED_BIT     = 0;
    localparam int STAT_CAPTURING_BIT = 1;
    localparam int STAT_DONE_BIT      = 2;
    localparam int STAT_COUNT_LSB     = 8;   // Frames captured modulo 256

    localparam logic [15:0] THRESH_RESET   = 16'h8000;
    localparam logic [23:0] ON_COLOR_RESET = 24'hFF_FFFF;  // Full white in GRB

endpackage

`default_nettype wire

/* src/cal_regs_apb.sv */
`timescale 1ns/1ps
`default_nettype none

module cal_regs_apb (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire                                 psel,
    input  wire                                 penable,
    input  wire                                 pwrite,
    input  wire  [cal_regs_pkg::APB_ADDR_W-1:0] paddr,
    input  wire  [cal_regs_pkg::APB_DATA_W-1:0] pwdata,
    output logic [cal_regs_pkg::APB_DATA_W-1:0] prdata,
    output logic                                pready,
    output logic                                pslverr,
    input  wire                                 armed,
    input  wire                                 capturing,
    input  wire                                 capture_done,
    output logic                                cal_enable,
    output logic                                pix_mode,
    output logic [led_cal_pkg::BIT_SEL_W-1:0]   bit_sel,
    output logic [led_cal_pkg::PIX_W-1:0]       threshold,
    output logic [23:0]                         on_color,
    output logic                                capture_arm
);
    import cal_regs_pkg::*;
    import led_cal_pkg::*;

    logic       access;        // APB access phase
    logic       mapped;
    logic       wr_en;
    logic       done_flag;     // Sticky until the next arm
    logic [7:0] frame_count;

    assign access  = psel && penable;
    assign pready  = 1'b1;     // Zero wait states
    assign pslverr = access && !mapped;
    assign wr_en   = access && pwrite && mapped;

    always_comb begin
        case (paddr)
            REG_CTRL, REG_BIT_SEL, REG_THRESH, REG_ON_COLOR, REG_STATUS: mapped = 1'b1;
            default: mapped = 1'b0;
        endcase
    end

    // Writes land on the access edge
    always_ff @(posedge clk) begin
        if (rst) begin
            cal_enable  <= 1'b0;
            pix_mode    <= 1'b0;
            bit_sel     <= '0;
            threshold   <= THRESH_RESET;
            on_color    <= ON_COLOR_RESET;
            capture_arm <= 1'b0;
        end else begin
            capture_arm <= 1'b0;                    // Single-cycle strobe
            if (wr_en) begin
                case (paddr)
                    REG_CTRL: begin
                        cal_enable  <= pwdata[CTRL_EN_BIT];
                        pix_mode    <= pwdata[CTRL_MODE_BIT];
                        // Arming needs the enable bit in the same write
                        capture_arm <= pwdata[CTRL_CAPTURE_BIT] && pwdata[CTRL_EN_BIT];
                    end
                    REG_BIT_SEL:  bit_sel   <= pwdata[BIT_SEL_W-1:0];
                    REG_THRESH:   threshold <= pwdata[PIX_W-1:0];
                    REG_ON_COLOR: on_color  <= pwdata[23:0];
                    default: ;                      // Status ignores writes
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            done_flag   <= 1'b0;
            frame_count <= '0;
        end else if (capture_done) begin
            done_flag   <= 1'b1;
            frame_count <= frame_count + 8'd1;     // Wraps at 256
        end else if (capture_arm) begin
            done_flag <= 1'b0;
        end
    end

    // Read mux, valid during access
    always_comb begin
        prdata = '0;
        case (paddr)
            REG_CTRL: begin
                prdata[CTRL_EN_BIT]   = cal_enable;
                prdata[CTRL_MODE_BIT] = pix_mode;   // Capture bit stays 0
            end
            REG_BIT_SEL:  prdata[BIT_SEL_W-1:0] = bit_sel;
            REG_THRESH:   prdata[PIX_W-1:0]     = threshold;
            REG_ON_COLOR: prdata[23:0]          = on_color;
            REG_STATUS: begin
                prdata[STAT_ARMED_BIT]        = armed;
                prdata[STAT_CAPTURING_BIT]    = capturing;
                prdata[STAT_DONE_BIT]         = done_flag;
                prdata[STAT_COUNT_LSB +: 8]   = frame_count;
            end
            default: prdata = '0;
        endcase
    end

endmodule

`default_nettype wire

/* src/id_shower.sv */
`timescale 1ns/1ps
`default_nettype none

module id_shower (
    input  wire                               clk,
    input  wire                               rst,
    input  wire                               led_req,
    input  wire  [led_cal_pkg::LED_ID_W-1:0]  led_index,
    input  wire                               cal_enable,
    input  wire  [led_cal_pkg::BIT_SEL_W-1:0] bit_sel,
    input  wire  [23:0]                       on_color,
    output logic [7:0]                        green_out,
    output logic [7:0]                        red_out,
    output logic [7:0]                        blue_out,
    output logic                              color_valid,
    output logic                              frame_shown
);
    import led_cal_pkg::*;

    logic [LED_ID_W-1:0] led_id;       // ID 0 is reserved for no LED
    logic [LED_ID_W-1:0] id_shifted;
    logic                in_range;
    logic                show_on;

    assign led_id     = led_index + LED_ID_W'(1);
    assign id_shifted = led_id >> bit_sel;   // Selected plane lands in bit 0
    assign in_range   = led_index < LED_ID_W'(NUM_LEDS);
    assign show_on    = cal_enable && in_range && id_shifted[0];

    // Colour follows the request by one cycle
    always_ff @(posedge clk) begin
        if (led_req) begin
            green_out <= show_on ? on_color[23:16] : 8'h00;  // GRB order
            red_out   <= show_on ? on_color[15:8]  : 8'h00;
            blue_out  <= show_on ? on_color[7:0]   : 8'h00;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            color_valid <= 1'b0;
            frame_shown <= 1'b0;
        end else begin
            color_valid <= led_req;
            // Last LED of the strand closes the refresh
            frame_shown <= led_req && (led_index == LED_ID_W'(NUM_LEDS - 1));
        end
    end

endmodule

`default_nettype wire

/* src/pixel_thresholder.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_thresholder (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                pix_valid,
    input  wire  [led_cal_pkg::PIX_ADDR_W-1:0] pix_addr,
    input  wire  [led_cal_pkg::PIX_W-1:0]      pix_data,
    input  wire                                pix_mode,
    input  wire  [led_cal_pkg::PIX_W-1:0]      threshold,
    output logic                               lit,
    output logic                               lit_valid,
    output logic [led_cal_pkg::PIX_ADDR_W-1:0] lit_addr
);
    import led_cal_pkg::*;

    pixel_word_u           pix_word;
    logic [7:0]            rgb_sum;     // 2r + g + 2b peaks at 187
    logic [PIX_W-1:0]      bright;
    logic [PIX_W-1:0]      bright_s1;
    logic                  valid_s1;
    logic [PIX_ADDR_W-1:0] addr_s1;

    assign pix_word = pix_data;
    assign rgb_sum  = {2'b00, pix_word.rgb565.r, 1'b0}
                    + {2'b00, pix_word.rgb565.g}
                    + {2'b00, pix_word.rgb565.b, 1'b0};
    assign bright   = pix_mode ? {rgb_sum, 8'h00} : pix_word.raw;  // RGB565 scaled by 256

    // Stage 1 brightness
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_s1 <= 1'b0;
        end else begin
            valid_s1 <= pix_valid;
        end
        bright_s1 <= bright;
        addr_s1   <= pix_addr;
    end

    // Stage 2 compare, lines up with the table read data
    always_ff @(posedge clk) begin
        if (rst) begin
            lit_valid <= 1'b0;
        end else begin
            lit_valid <= valid_s1;
        end
        lit      <= bright_s1 > threshold;   // Strictly above
        lit_addr <= addr_s1;
    end

endmodule

`default_nettype wire

/* src/cal_table.sv */
`timescale 1ns/1ps
`default_nettype none

module cal_table (
    input  wire                                clk,
    input  wire                                rst,
    input  wire                                cal_enable,
    input  wire                                capture_arm,
    input  wire                                pix_valid,
    input  wire                                pix_sof,
    input  wire  [led_cal_pkg::PIX_ADDR_W-1:0] pix_addr,
    input  wire                                lit,
    input  wire                                lit_valid,
    input  wire  [led_cal_pkg::PIX_ADDR_W-1:0] lit_addr,
    input  wire  [led_cal_pkg::PIX_ADDR_W-1:0] tbl_rd_addr,
    output logic [led_cal_pkg::LED_ID_W-1:0]   tbl_rd_data,
    output logic                               armed,
    output logic                               capturing,
    output logic                               capture_done
);
    import led_cal_pkg::*;

    logic [LED_ID_W-1:0]      mem [NUM_PIXELS];
    logic [LED_ID_W-1:0]      rd_a_pipe [TABLE_LATENCY];   // Read-modify-write side
    logic [LED_ID_W-1:0]      rd_b_pipe [TABLE_LATENCY];   // Video reader side
    logic [TABLE_LATENCY-1:0] cap_pipe;                    // Capture tag per pixel in flight
    logic                     capture_run;                 // Frame pixels still arriving
    logic                     draining;                    // Last pixel not yet written
    logic                     start_frame;
    logic                     cap_pixel;
    logic                     last_in;
    logic                     wr_en;
    logic                     wr_last;

    assign start_frame = armed && pix_valid && pix_sof;
    assign cap_pixel   = pix_valid && (capture_run || start_frame);
    assign last_in     = cap_pixel && (pix_addr == PIX_ADDR_W'(NUM_PIXELS - 1));
    assign wr_en       = cal_enable && lit_valid && cap_pipe[TABLE_LATENCY-1];
    assign wr_last     = wr_en && (lit_addr == PIX_ADDR_W'(NUM_PIXELS - 1));
    assign capturing   = capture_run || draining;
    assign tbl_rd_data = rd_b_pipe[TABLE_LATENCY-1];

    // Capture sequencing, idle then armed then capturing
    always_ff @(posedge clk) begin
        if (rst || !cal_enable) begin
            armed        <= 1'b0;
            capture_run  <= 1'b0;
            draining     <= 1'b0;
            capture_done <= 1'b0;
        end else begin
            if (start_frame) begin
                armed <= 1'b0;
            end else if (capture_arm && !capturing) begin
                armed <= 1'b1;
            end
            if (last_in) begin
                capture_run <= 1'b0;
                draining    <= 1'b1;
            end else if (start_frame) begin
                capture_run <= 1'b1;
            end else if (wr_last) begin
                draining <= 1'b0;
            end
            capture_done <= wr_last;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cap_pipe <= '0;
        end else begin
            cap_pipe <= {cap_pipe[TABLE_LATENCY-2:0], cap_pixel};
        end
    end

    // Port A, old entry shifts left and takes the new bit
    always_ff @(posedge clk) begin
        rd_a_pipe[0] <= mem[pix_addr];   // Read-first on collision
        for (int i = 1; i < TABLE_LATENCY; i++) begin
            rd_a_pipe[i] <= rd_a_pipe[i-1];
        end
        if (wr_en) begin
            mem[lit_addr] <= {rd_a_pipe[TABLE_LATENCY-1][LED_ID_W-2:0], lit};
        end
    end

    // Port B read only
    always_ff @(posedge clk) begin
        rd_b_pipe[0] <= mem[tbl_rd_addr];
        for (int i = 1; i < TABLE_LATENCY; i++) begin
            rd_b_pipe[i] <= rd_b_pipe[i-1];
        end
    end

endmodule

`default_nettype wire

/* src/led_cal_top.sv */
`timescale 1ns/1ps
`default_nettype none

module led_cal_top (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire                                 psel,
    input  wire                                 penable,
    input  wire                                 pwrite,
    input  wire  [cal_regs_pkg::APB_ADDR_W-1:0] paddr,
    input  wire  [cal_regs_pkg::APB_DATA_W-1:0] pwdata,
    output logic [cal_regs_pkg::APB_DATA_W-1:0] prdata,
    output logic                                pready,
    output logic                                pslverr,
    input  wire                                 pix_valid,
    input  wire                                 pix_sof,
    input  wire  [led_cal_pkg::PIX_ADDR_W-1:0]  pix_addr,
    input  wire  [led_cal_pkg::PIX_W-1:0]       pix_data,
    input  wire                                 led_req,
    input  wire  [led_cal_pkg::LED_ID_W-1:0]    led_index,
    output logic [7:0]                          green_out,
    output logic [7:0]                          red_out,
    output logic [7:0]                          blue_out,
    output logic                                color_valid,
    output logic                                frame_shown,
    input  wire  [led_cal_pkg::PIX_ADDR_W-1:0]  tbl_rd_addr,
    output logic [led_cal_pkg::LED_ID_W-1:0]    tbl_rd_data
);
    import led_cal_pkg::*;

    // Register outputs steering the datapath
    logic                  cal_enable;
    logic                  pix_mode;
    logic [BIT_SEL_W-1:0]  bit_sel;
    logic [PIX_W-1:0]      threshold;
    logic [23:0]           on_color;
    logic                  capture_arm;
    // Table status back to the registers
    logic                  armed;
    logic                  capturing;
    logic                  capture_done;
    // Thresholder to table, two cycles after the pixel
    logic                  lit;
    logic                  lit_valid;
    logic [PIX_ADDR_W-1:0] lit_addr;

    cal_regs_apb cal_regs_apb_inst (
        .clk(clk), .rst(rst),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .armed(armed), .capturing(capturing), .capture_done(capture_done),
        .cal_enable(cal_enable), .pix_mode(pix_mode), .bit_sel(bit_sel),
        .threshold(threshold), .on_color(on_color), .capture_arm(capture_arm)
    );

    id_shower id_shower_inst (
        .clk(clk), .rst(rst),
        .led_req(led_req), .led_index(led_index),
        .cal_enable(cal_enable), .bit_sel(bit_sel), .on_color(on_color),
        .green_out(green_out), .red_out(red_out), .blue_out(blue_out),
        .color_valid(color_valid), .frame_shown(frame_shown)
    );

    pixel_thresholder pixel_thresholder_inst (
        .clk(clk), .rst(rst),
        .pix_valid(pix_valid), .pix_addr(pix_addr), .pix_data(pix_data),
        .pix_mode(pix_mode), .threshold(threshold),
        .lit(lit), .lit_valid(lit_valid), .lit_addr(lit_addr)
    );

    cal_table cal_table_inst (
        .clk(clk), .rst(rst),
        .cal_enable(cal_enable), .capture_arm(capture_arm),
        .pix_valid(pix_valid), .pix_sof(pix_sof), .pix_addr(pix_addr),
        .lit(lit), .lit_valid(lit_valid), .lit_addr(lit_addr),
        .tbl_rd_addr(tbl_rd_addr), .tbl_rd_data(tbl_rd_data),
        .armed(armed), .capturing(capturing), .capture_done(capture_done)
    );

endmodule

`default_nettype wire

/* bench/clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;   // 20 ns period
    end

    // Reset spans the first two rising edges
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

`default_nettype wire

/* bench/led_cal_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module led_cal_tb;
    import led_cal_pkg::*;
    import cal_regs_pkg::*;

    // Ten gapped frames and four table sweeps come to about 300k cycles
    localparam int CYCLE_LIMIT = 400000;

    logic                  clk;
    logic                  rst;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [APB_DATA_W-1:0] pwdata;
    logic [APB_DATA_W-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
    logic                  pix_valid;
    logic                  pix_sof;
    logic [PIX_ADDR_W-1:0] pix_addr;
    logic [PIX_W-1:0]      pix_data;
    logic                  led_req;
    logic [LED_ID_W-1:0]   led_index;
    logic [7:0]            green_out;
    logic [7:0]            red_out;
    logic [7:0]            blue_out;
    logic                  color_valid;
    logic                  frame_shown;
    logic [PIX_ADDR_W-1:0] tbl_rd_addr;
    logic [LED_ID_W-1:0]   tbl_rd_data;

    logic [LED_ID_W-1:0] model_tbl [NUM_PIXELS];   // Expected table entries
    logic [LED_ID_W-1:0] owner [NUM_PIXELS];       // LED ID seen at each pixel
    logic [PIX_W-1:0]    frame_data [NUM_PIXELS];
    logic [31:0]         rng_state;
    logic                cur_mode;                 // Mirrors CTRL pix_mode
    logic [PIX_W-1:0]    cur_thresh;
    logic [31:0]         rd_word;                  // Last APB read data
    logic                last_slverr;
    int                  errors;
    int                  prop_errors = 0;          // Concurrent assertion failures
    int                  mark;
    int                  tests_failed;
    int                  cycle_count = 0;

    clk_gen clk_gen_inst (.clk(clk), .rst(rst));

    led_cal_top led_cal_top_inst (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // Brightness rule with a strict compare against the threshold
    function automatic logic expected_lit(input logic [PIX_W-1:0] d);
        int bright;
        if (cur_mode)
            bright = (2 * int'(d[15:11]) + int'(d[10:5]) + 2 * int'(d[4:0])) * 256;
        else
            bright = int'(d);   // Raw grey
        return bright > int'(cur_thresh);
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("Mismatch at %0t: %s expected %h, actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;   // Drive just after the edge
    endtask

    task automatic apb_xfer(input logic wr, input logic [APB_ADDR_W-1:0] addr,
                            input logic [31:0] data);
        next_cycle();
        psel    = 1'b1;   // Setup
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        next_cycle();
        penable = 1'b1;   // Access phase where the write lands on the next edge
        #5;
        rd_word     = prdata;
        last_slverr = pslverr;
        next_cycle();
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic check_reg(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] exp);
        apb_xfer(1'b0, addr, 32'h0);
        check_value($sformatf("prdata @%02h", addr), exp, rd_word);
        check_value("pslverr", 32'h0, 32'(last_slverr));
    endtask

    // Whole frame with random idle gaps and the model shifted per pixel
    task automatic stream_frame(input logic update);
        int a;
        a = 0;
        while (a < NUM_PIXELS) begin
            next_cycle();
            rng_state = xorshift(rng_state);
            pix_valid = rng_state[2:0] != 3'd0;   // About one idle cycle in eight
            pix_sof   = pix_valid && a == 0;
            pix_addr  = PIX_ADDR_W'(a);
            pix_data  = frame_data[a];
            if (pix_valid) begin
                if (update)
                    model_tbl[a] = {model_tbl[a][LED_ID_W-2:0], expected_lit(frame_data[a])};
                a++;
            end
        end
        next_cycle();
        pix_valid = 1'b0;
        pix_sof   = 1'b0;
    endtask

    task automatic wait_capture_done();
        int polls;
        polls   = 0;
        rd_word = '0;
        while (!rd_word[STAT_DONE_BIT] && polls < 16) begin
            apb_xfer(1'b0, REG_STATUS, 32'h0);
            polls++;
        end
        assert (rd_word[STAT_DONE_BIT]) else begin
            $display("Capture never reported done after %0d status reads", polls);
            errors++;
        end
    endtask

    // Reader port data trails the address by two cycles
    task automatic sweep_table();
        int a;
        for (a = 0; a < NUM_PIXELS + TABLE_LATENCY; a++) begin
            next_cycle();
            if (a >= TABLE_LATENCY)
                check_value("tbl_rd_data", 32'(model_tbl[a - TABLE_LATENCY]), 32'(tbl_rd_data));
            tbl_rd_addr = PIX_ADDR_W'(a % NUM_PIXELS);
        end
    endtask

    task automatic finish_test(input string name);
        int n;
        n = errors + prop_errors - mark;
        $display("Test %-12s %s (%0d errors)", name, n == 0 ? "ok" : "FAILED", n);
        if (n != 0)
            tests_failed++;
        mark = errors + prop_errors;
    endtask

    initial begin : main
        int   a;
        int   p;
        int   en;
        logic on;
        $timeformat(-9, 0, " ns", 0);
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        pix_valid = 1'b0;
        pix_sof = 1'b0;
        pix_addr = '0;
        pix_data = '0;
        led_req = 1'b0;
        led_index = '0;
        tbl_rd_addr = '0;
        rng_state = 32'h1a53c732;
        errors = 0;
        mark = 0;
        tests_failed = 0;
        cur_mode = 1'b0;
        cur_thresh = 16'h8000;
        for (a = 0; a < NUM_PIXELS; a++)
            model_tbl[a] = '0;
        @(negedge rst);

        // Reset values, readback and unmapped offsets
        check_value("color_valid", 32'h0, 32'(color_valid));
        check_value("frame_shown", 32'h0, 32'(frame_shown));
        check_value("pslverr", 32'h0, 32'(pslverr));
        check_reg(REG_CTRL, 32'h0);
        check_reg(REG_BIT_SEL, 32'h0);
        check_reg(REG_THRESH, 32'h8000);
        check_reg(REG_ON_COLOR, 32'h00FF_FFFF);
        check_reg(REG_STATUS, 32'h0);
        apb_xfer(1'b1, REG_CTRL, 32'h102);        // Capture bit, enable low
        apb_xfer(1'b1, REG_BIT_SEL, 32'h5);
        apb_xfer(1'b1, REG_THRESH, 32'h1234);
        apb_xfer(1'b1, REG_ON_COLOR, 32'h00A1_B2C3);
        apb_xfer(1'b1, 8'h14, 32'hFFFF_FFFF);
        check_value("pslverr", 32'h1, 32'(last_slverr));
        apb_xfer(1'b0, 8'h40, 32'h0);
        check_value("pslverr", 32'h1, 32'(last_slverr));
        check_reg(REG_CTRL, 32'h2);
        check_reg(REG_BIT_SEL, 32'h5);
        check_reg(REG_THRESH, 32'h1234);
        check_reg(REG_ON_COLOR, 32'h00A1_B2C3);
        check_reg(REG_STATUS, 32'h0);
        finish_test("registers");

        // Every plane and index with the enable on then off
        for (en = 1; en >= 0; en--) begin
            apb_xfer(1'b1, REG_CTRL, 32'(en));
            for (p = 0; p < NUM_PLANES; p++) begin
                apb_xfer(1'b1, REG_BIT_SEL, 32'(p));
                for (a = 0; a < NUM_LEDS + 2; a++) begin   // Two indices past the strand
                    next_cycle();
                    led_req   = 1'b1;
                    led_index = LED_ID_W'(a);
                    next_cycle();
                    led_req = 1'b0;
                    on = en == 1 && a < NUM_LEDS && (((a + 1) >> p) & 1) == 1;
                    check_value("{green_out,red_out,blue_out}", on ? 32'h00A1_B2C3 : 32'h0,
                                {8'h0, green_out, red_out, blue_out});
                    check_value("color_valid", 32'h1, 32'(color_valid));
                    check_value("frame_shown", 32'(a == NUM_LEDS - 1), 32'(frame_shown));
                end
            end
        end
        finish_test("id_shower");

        // Seven raw captures from the MSB plane down
        apb_xfer(1'b1, REG_THRESH, 32'h8000);
        apb_xfer(1'b1, REG_CTRL, 32'h1);
        for (a = 0; a < NUM_PIXELS; a++) begin
            rng_state = xorshift(rng_state);
            owner[a]  = LED_ID_W'(rng_state % (NUM_LEDS + 1));   // 0 is no LED
        end
        for (p = NUM_PLANES - 1; p >= 0; p--) begin
            apb_xfer(1'b1, REG_BIT_SEL, 32'(p));
            for (a = 0; a < NUM_PIXELS; a++) begin
                rng_state = xorshift(rng_state);
                if (owner[a][p])
                    frame_data[a] = 16'h8001 + PIX_W'(rng_state[13:0]);
                else
                    frame_data[a] = 16'h8000 - PIX_W'(rng_state[14:0]);   // Down to the threshold
            end
            apb_xfer(1'b1, REG_CTRL, 32'h101);
            stream_frame(1'b1);
            wait_capture_done();
        end
        sweep_table();
        check_reg(REG_STATUS, 32'h0704);
        finish_test("raw_calib");

        // One RGB565 plane on top of the calibrated IDs
        apb_xfer(1'b1, REG_THRESH, 32'h5C00);
        cur_mode   = 1'b1;
        cur_thresh = 16'h5C00;
        for (a = 0; a < NUM_PIXELS; a++) begin
            rng_state     = xorshift(rng_state);
            frame_data[a] = rng_state[15:0];
        end
        apb_xfer(1'b1, REG_CTRL, 32'h103);
        stream_frame(1'b1);
        wait_capture_done();
        sweep_table();
        check_reg(REG_STATUS, 32'h0804);
        finish_test("rgb565");

        // Nothing arms and nothing is written while disabled
        apb_xfer(1'b1, REG_CTRL, 32'h100);
        cur_mode = 1'b0;
        check_reg(REG_STATUS, 32'h0804);
        stream_frame(1'b0);
        repeat (4) next_cycle();
        check_reg(REG_STATUS, 32'h0804);
        sweep_table();
        finish_test("disabled");

        // Stray pixels ahead of sof and capturing seen mid frame
        apb_xfer(1'b1, REG_THRESH, 32'h8000);
        apb_xfer(1'b1, REG_CTRL, 32'h1);
        cur_thresh = 16'h8000;
        apb_xfer(1'b1, REG_CTRL, 32'h101);
        check_reg(REG_STATUS, 32'h0801);          // Armed with done cleared
        for (a = 0; a < 64; a++) begin
            next_cycle();
            pix_valid = 1'b1;
            pix_sof   = 1'b0;
            pix_addr  = PIX_ADDR_W'(a);
            pix_data  = 16'hFFFF;
        end
        next_cycle();
        pix_valid = 1'b0;
        check_reg(REG_STATUS, 32'h0801);
        for (a = 0; a < NUM_PIXELS; a++) begin
            rng_state     = xorshift(rng_state);
            frame_data[a] = rng_state[15:0];
        end
        fork
            stream_frame(1'b1);
            begin
                repeat (200) next_cycle();
                check_reg(REG_STATUS, 32'h0802);
            end
        join
        wait_capture_done();
        check_reg(REG_STATUS, 32'h0904);
        sweep_table();
        finish_test("sof_gating");

        $display("Tests: 6 run, %0d failed, %0d errors", tests_failed, errors + prop_errors);
        if (errors + prop_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    assert property (@(posedge clk) disable iff (rst) led_req |=> color_valid) else begin
        $display("Mismatch at %0t: color_valid expected 1, actual 0", $time);
        prop_errors++;
    end
    assert property (@(posedge clk) disable iff (rst) !led_req |=> !color_valid) else begin
        $display("Mismatch at %0t: color_valid expected 0, actual 1", $time);
        prop_errors++;
    end
    assert property (@(posedge clk) disable iff (rst) frame_shown |-> color_valid) else begin
        $display("frame_shown at %0t came without a colour", $time);
        prop_errors++;
    end
    assert property (@(posedge clk) disable iff (rst) !(psel && penable) |-> !pslverr) else begin
        $display("pslverr at %0t raised outside an access phase", $time);
        prop_errors++;
    end
    assert property (@(posedge clk) disable iff (rst) (psel && penable) |-> pready) else begin
        $display("Mismatch at %0t: pready expected 1, actual 0", $time);
        prop_errors++;
    end

    // Watchdog
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == CYCLE_LIMIT) begin
            $display("Timeout: run reached %0d cycles without finishing", CYCLE_LIMIT);
            $display("Done: errors found");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* filelist.f */
src/led_cal_pkg.sv
src/cal_regs_pkg.sv
src/cal_regs_apb.sv
src/id_shower.sv
src/pixel_thresholder.sv
src/cal_table.sv
src/led_cal_top.sv
bench/clk_gen.sv
bench/led_cal_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the LED calibration testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps \
    --top-module led_cal_tb -f filelist.f \
    --Mdir obj_dir -o led_cal_sim

./obj_dir/led_cal_sim 2>&1 | tee sim.log

if grep -q "Done: errors found" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
if ! grep -q "Done: no errors" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"
